/* include/rom_image.svh */
// Boot ROM contents table, included inside the boot ROM and the testbench for reference reads

// Boot code, one 64-bit word per entry
localparam logic [soc_pkg::DataWidth-1:0] rom_image [soc_pkg::RomWords] = '{
  // Reset vector: hart id and device tree pointer setup
  64'h0000_0297_f140_2573,
  64'h0202_8593_0000_0513,
  64'h0182_b283_0000_0297,
  64'h0000_0013_0002_8067,
  // Jump target and boot flags
  64'h0000_0000_8000_0000,
  64'h0000_0000_0000_0001,
  64'h1234_5678_9abc_def0,
  64'h0fed_cba9_8765_4321,
  // Trap stub
  64'h3050_2073_0000_0297,
  64'h1050_0073_ffdf_f06f,
  64'h0000_0000_0000_0000,
  64'h5a5a_a5a5_5a5a_a5a5,
  // Signature words
  64'hdead_beef_cafe_f00d,
  64'h0123_4567_89ab_cdef,
  64'hffff_0000_ffff_0000,
  64'h8000_1ff8_0000_0001
};

/* hdl/soc_pkg.sv */
// Shared bus widths, address map and sizing constants for the Wishbone memory subsystem
`default_nettype none

package soc_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned SelWidth       = DataWidth / 8;
  // Byte offset bits below a word index
  localparam int unsigned WordOffsetBits = $clog2(SelWidth);

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  // Boot ROM region, 4 KiB
  localparam logic [AddrWidth-1:0] RomBase    = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength  = 32'h0000_1000;
  // Main SRAM region, 8 KiB
  localparam logic [AddrWidth-1:0] SramBase   = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] SramLength = 32'h0000_2000;

  // ----------------------------------------
  // Memory sizing
  // ----------------------------------------
  // Word index width covering the whole ROM region
  localparam int unsigned RomIdxWidth  = $clog2(RomLength / SelWidth);
  // Entries actually present in the ROM table
  localparam int unsigned RomWords     = 16;
  localparam int unsigned RomTableBits = $clog2(RomWords);

  localparam int unsigned SramWords    = 1024;
  localparam int unsigned SramIdxWidth = $clog2(SramWords);

  // Last SRAM word doubles as the exit register, byte address 0x8000_1FF8
  localparam int unsigned ExitWord  = SramWords - 1;
  localparam int unsigned ExitWidth = 32;

  // ----------------------------------------
  // Debug request gating
  // ----------------------------------------
  // Cycles after reset during which debug requests are held off
  localparam int unsigned DmiDelCycles = 20;
  localparam int unsigned DelCntWidth  = $clog2(DmiDelCycles + 1);

endpackage

`default_nettype wire

/* hdl/wb_addr_decode.sv */
// Wishbone address decoder: steers the strobe to ROM or SRAM and answers errors itself
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Master side
  input  logic                          cyc_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] adr_i,
  output logic                          ack_o,
  output logic                          err_o,
  output logic [soc_pkg::DataWidth-1:0] dat_o,
  // Boot ROM
  output logic                          rom_stb_o,
  input  logic                          rom_ack_i,
  input  logic [soc_pkg::DataWidth-1:0] rom_dat_i,
  // SRAM
  output logic                          sram_stb_o,
  input  logic                          sram_ack_i,
  input  logic [soc_pkg::DataWidth-1:0] sram_dat_i
);

  logic req;
  logic rom_hit;
  logic sram_hit;
  logic err_d;
  logic err_q;

  // ----------------------------------------
  // Region decode
  // ----------------------------------------
  assign req = cyc_i & stb_i;

  assign rom_hit = (adr_i >= soc_pkg::RomBase) &&
                   (adr_i < soc_pkg::RomBase + soc_pkg::RomLength);

  assign sram_hit = (adr_i >= soc_pkg::SramBase) &&
                    (adr_i < soc_pkg::SramBase + soc_pkg::SramLength);

  // ROM only sees reads, a write there falls through to the error path
  assign rom_stb_o  = req & rom_hit & ~we_i;
  assign sram_stb_o = req & sram_hit;

  // ----------------------------------------
  // Error responder
  // ----------------------------------------
  // Blocked while high so a held strobe gets a single err
  assign err_d = req & ~rom_stb_o & ~sram_stb_o & ~err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_err
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_d;
    end
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  assign ack_o = rom_ack_i | sram_ack_i;
  assign err_o = err_q;

  // Data follows whichever slave acknowledged
  always_comb begin : p_rdata
    if (rom_ack_i) begin
      dat_o = rom_dat_i;
    end else if (sram_ack_i) begin
      dat_o = sram_dat_i;
    end else begin
      dat_o = '0;
    end
  end

  // Regions do not overlap
  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_stb_o && sram_stb_o))
    else $error("both slave strobes active");

  // Slave acks and decoder errors must never collide
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ack_o && err_o))
    else $error("ack and err high together");

endmodule

`default_nettype wire

/* hdl/boot_rom.sv */
// Read-only boot memory with a registered Wishbone-style response, fed by the decoder strobe
`timescale 1ns/1ps
`default_nettype none

module boot_rom (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            stb_i,
  input  logic [soc_pkg::RomIdxWidth-1:0] word_i,
  output logic                            ack_o,
  output logic [soc_pkg::DataWidth-1:0]   dat_o
);

`include "rom_image.svh"

  logic                          access;
  logic                          ack_q;
  logic [soc_pkg::DataWidth-1:0] rd_d;
  logic [soc_pkg::DataWidth-1:0] rd_q;

  // One response per strobe
  assign access = stb_i & ~ack_q;

  // ----------------------------------------
  // Table lookup
  // ----------------------------------------
  // Region is larger than the table, the rest reads as zero
  always_comb begin : p_lookup
    if (word_i < soc_pkg::RomWords) begin
      rd_d = rom_image[word_i[soc_pkg::RomTableBits-1:0]];
    end else begin
      rd_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin : p_data
    if (access) begin
      rd_q <= rd_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ack
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rd_q;

endmodule

`default_nettype wire

/* hdl/wb_sram.sv */
// Byte-writable SRAM slave with registered ack and a capture register on the exit word
`timescale 1ns/1ps
`default_nettype none

module wb_sram (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [soc_pkg::SramIdxWidth-1:0] word_i,
  input  logic [soc_pkg::SelWidth-1:0]     sel_i,
  input  logic [soc_pkg::DataWidth-1:0]    dat_i,
  output logic                             ack_o,
  output logic [soc_pkg::DataWidth-1:0]    dat_o,
  output logic [soc_pkg::ExitWidth-1:0]    exit_o
);

  logic [soc_pkg::DataWidth-1:0] mem_q [soc_pkg::SramWords];

  logic                          access;
  logic                          exit_hit;
  logic                          ack_q;
  logic [soc_pkg::DataWidth-1:0] wr_word;
  logic [soc_pkg::DataWidth-1:0] rd_q;
  logic [soc_pkg::ExitWidth-1:0] exit_q;

  // Held strobe is served only once
  assign access = stb_i & ~ack_q;

  assign exit_hit = (word_i == soc_pkg::ExitWord[soc_pkg::SramIdxWidth-1:0]);

  // ----------------------------------------
  // Byte merge
  // ----------------------------------------
  // Stored word with the selected bytes replaced
  always_comb begin : p_merge
    wr_word = mem_q[word_i];
    for (int b = 0; b < soc_pkg::SelWidth; b++) begin
      if (sel_i[b]) begin
        wr_word[8*b +: 8] = dat_i[8*b +: 8];
      end
    end
  end

  // ----------------------------------------
  // Storage and read port
  // ----------------------------------------
  always_ff @(posedge clk_i) begin : p_mem
    if (access) begin
      if (we_i) begin
        mem_q[word_i] <= wr_word;
      end else begin
        rd_q <= mem_q[word_i];
      end
    end
  end

  // ----------------------------------------
  // Response and exit register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      exit_q <= '0;
    end else begin
      ack_q <= access;
      // Low half of the word as it ends up in memory
      if (access && we_i && exit_hit) begin
        exit_q <= wr_word[soc_pkg::ExitWidth-1:0];
      end
    end
  end

  assign ack_o  = ack_q;
  assign dat_o  = rd_q;
  assign exit_o = exit_q;

  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_q |=> !ack_q)
    else $error("sram ack high in consecutive cycles");

endmodule

`default_nettype wire

/* hdl/debug_req_gate.sv */
// Holds off the external debug request for a fixed window after reset and while debug is disabled
`timescale 1ns/1ps
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  logic [soc_pkg::DelCntWidth-1:0] cnt_d;
  logic [soc_pkg::DelCntWidth-1:0] cnt_q;
  logic                            cnt_busy;

  // ----------------------------------------
  // Post-reset window
  // ----------------------------------------
  // Gives boot code time to run before a debug request can interrupt it.
  assign cnt_busy = (cnt_q != '0);

  // Count down and stick at zero
  assign cnt_d = cnt_busy ? cnt_q - 1'b1 : cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_del_cnt
    if (!rst_ni) begin
      cnt_q <= soc_pkg::DmiDelCycles[soc_pkg::DelCntWidth-1:0];
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Request passes only after the window and while enabled
  assign debug_req_o = ~cnt_busy & debug_req_i & debug_en_i;

  a_hold_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_busy |-> !debug_req_o)
    else $error("debug request inside hold-off window");

endmodule

`default_nettype wire

/* hdl/wb_soc_top.sv */
// Memory subsystem top: connects the external Wishbone master to decoder, boot ROM, SRAM and debug gate
`timescale 1ns/1ps
`default_nettype none

module wb_soc_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Wishbone master port
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] wb_adr_i,
  input  logic [soc_pkg::SelWidth-1:0]  wb_sel_i,
  input  logic [soc_pkg::DataWidth-1:0] wb_dat_i,
  output logic [soc_pkg::DataWidth-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o,
  // Debug
  input  logic                          debug_req_i,
  input  logic                          debug_en_i,
  output logic                          debug_req_o,
  // Exit value
  output logic [soc_pkg::ExitWidth-1:0] exit_o
);

  logic                          rom_stb;
  logic                          rom_ack;
  logic [soc_pkg::DataWidth-1:0] rom_dat;
  logic                          sram_stb;
  logic                          sram_ack;
  logic [soc_pkg::DataWidth-1:0] sram_dat;

  // ----------------------------------------
  // Decoder
  // ----------------------------------------
  wb_addr_decode i_decode (
    .clk_i      ( clk_i    ),
    .rst_ni     ( rst_ni   ),
    .cyc_i      ( wb_cyc_i ),
    .stb_i      ( wb_stb_i ),
    .we_i       ( wb_we_i  ),
    .adr_i      ( wb_adr_i ),
    .ack_o      ( wb_ack_o ),
    .err_o      ( wb_err_o ),
    .dat_o      ( wb_dat_o ),
    .rom_stb_o  ( rom_stb  ),
    .rom_ack_i  ( rom_ack  ),
    .rom_dat_i  ( rom_dat  ),
    .sram_stb_o ( sram_stb ),
    .sram_ack_i ( sram_ack ),
    .sram_dat_i ( sram_dat )
  );

  // ----------------------------------------
  // Memories
  // ----------------------------------------
  // Word index taken straight from the address above the byte offset
  boot_rom i_boot_rom (
    .clk_i  ( clk_i                                                      ),
    .rst_ni ( rst_ni                                                     ),
    .stb_i  ( rom_stb                                                    ),
    .word_i ( wb_adr_i[soc_pkg::WordOffsetBits +: soc_pkg::RomIdxWidth]  ),
    .ack_o  ( rom_ack                                                    ),
    .dat_o  ( rom_dat                                                    )
  );

  wb_sram i_sram (
    .clk_i  ( clk_i                                                      ),
    .rst_ni ( rst_ni                                                     ),
    .stb_i  ( sram_stb                                                   ),
    .we_i   ( wb_we_i                                                    ),
    .word_i ( wb_adr_i[soc_pkg::WordOffsetBits +: soc_pkg::SramIdxWidth] ),
    .sel_i  ( wb_sel_i                                                   ),
    .dat_i  ( wb_dat_i                                                   ),
    .ack_o  ( sram_ack                                                   ),
    .dat_o  ( sram_dat                                                   ),
    .exit_o ( exit_o                                                     )
  );

  // ----------------------------------------
  // Debug request gating
  // ----------------------------------------
  debug_req_gate i_debug_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

/* sim/tb_wb_soc_top.sv */
// Self-checking testbench for the Wishbone memory subsystem, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_wb_soc_top;

`include "rom_image.svh"

  localparam int unsigned TimeoutCycles = 2000;
  // Byte address of the last SRAM word
  localparam logic [31:0] ExitAdr = 32'h8000_1ff8;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [7:0]  wb_sel;
  logic [63:0] wb_wdat;
  logic [63:0] wb_rdat;
  logic        wb_ack;
  logic        wb_err;
  logic        dbg_req;
  logic        dbg_en;
  logic        dbg_req_out;
  logic [31:0] exit_val;

  // Reference state
  logic [63:0]  sram_model [soc_pkg::SramWords];
  bit           written [soc_pkg::SramWords];
  int unsigned  used_words[$];
  logic [31:0]  exit_exp = '0;
  int           seed;
  int unsigned  cycle_cnt = 0;
  int unsigned  since_rst = 0;

  always #20 clk = ~clk;

  wb_soc_top dut0 (
    .clk_i       ( clk         ),
    .rst_ni      ( rst_n       ),
    .wb_cyc_i    ( wb_cyc      ),
    .wb_stb_i    ( wb_stb      ),
    .wb_we_i     ( wb_we       ),
    .wb_adr_i    ( wb_adr      ),
    .wb_sel_i    ( wb_sel      ),
    .wb_dat_i    ( wb_wdat     ),
    .wb_dat_o    ( wb_rdat     ),
    .wb_ack_o    ( wb_ack      ),
    .wb_err_o    ( wb_err      ),
    .debug_req_i ( dbg_req     ),
    .debug_en_i  ( dbg_en      ),
    .debug_req_o ( dbg_req_out ),
    .exit_o      ( exit_val    )
  );

  task automatic report_error(input string msg);
    $display("ERR %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Old word with the selected bytes taken from the new data
  function automatic logic [63:0] apply_sel(input logic [63:0] old_w, input logic [63:0] new_w,
                                            input logic [7:0] sel);
    logic [63:0] mask;
    mask = '0;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{sel[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // ----------------------------------------
  // Bus master
  // ----------------------------------------
  task automatic bus_xfer(input logic we, input logic [31:0] adr, input logic [7:0] sel,
                          input logic [63:0] dat, input logic exp_err, input logic hold,
                          output logic [63:0] rdat);
    int  n;
    logic got;
    n = 0;
    got = 1'b0;
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_sel  <= sel;
    wb_wdat <= dat;
    while (!got) begin
      @(negedge clk);
      n++;
      if (wb_ack || wb_err) begin
        got = 1'b1;
        if (we && !exp_err && adr == ExitAdr) begin
          exit_exp = sram_model[soc_pkg::ExitWord][31:0];
        end
      end
      assert (exit_val == exit_exp) else report_error($sformatf("exit_o %h, expected %h",
                                                      exit_val, exit_exp));
    end
    assert (n == 2) else report_error($sformatf("response after %0d half cycles", n));
    assert (wb_err == exp_err && wb_ack == !exp_err)
      else report_error($sformatf("adr %h: ack %b err %b, expected err %b",
                                  adr, wb_ack, wb_err, exp_err));
    rdat = wb_rdat;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // Strobe was still high at this edge and must not be served again
    if (hold) begin
      @(negedge clk);
      assert (!(wb_ack || wb_err)) else report_error("held strobe got a second response");
    end
  endtask

  task automatic rom_check(input int unsigned idx, input logic hold);
    logic [63:0] rd;
    logic [63:0] exp;
    exp = (idx < soc_pkg::RomWords) ? rom_image[idx] : 64'h0;
    bus_xfer(1'b0, soc_pkg::RomBase + 32'(idx * 8), 8'hff, 64'h0, 1'b0, hold, rd);
    assert (rd == exp) else report_error($sformatf("ROM word %0d read %h, expected %h",
                                                   idx, rd, exp));
  endtask

  task automatic sram_write(input int unsigned idx, input logic [7:0] sel,
                            input logic [63:0] dat, input logic hold);
    logic [63:0] rd;
    sram_model[idx] = apply_sel(sram_model[idx], dat, sel);
    bus_xfer(1'b1, soc_pkg::SramBase + 32'(idx * 8), sel, dat, 1'b0, hold, rd);
  endtask

  task automatic sram_check(input int unsigned idx);
    logic [63:0] rd;
    bus_xfer(1'b0, soc_pkg::SramBase + 32'(idx * 8), 8'hff, 64'h0, 1'b0, 1'b0, rd);
    assert (rd == sram_model[idx])
      else report_error($sformatf("SRAM word %0d read %h, expected %h",
                                  idx, rd, sram_model[idx]));
  endtask

  // ----------------------------------------
  // Protocol and debug checks
  // ----------------------------------------
  a_ack_err: assert property (@(posedge clk) disable iff (!rst_n) !(wb_ack && wb_err))
    else report_error("ack and err high together");

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wb_stb) |=> (wb_ack || wb_err))
    else report_error("no response one cycle after strobe");

  a_single_resp: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ack || wb_err) |=> !(wb_ack || wb_err))
    else report_error("response high in two consecutive cycles");

  // Request blocked for DmiDelCycles cycles after reset release
  always @(negedge clk) begin : p_debug_mon
    if (rst_n) begin
      since_rst = since_rst + 1;
      assert (dbg_req_out == ((since_rst > soc_pkg::DmiDelCycles) && dbg_req && dbg_en))
        else report_error($sformatf("debug_req_o %b in cycle %0d after reset",
                                    dbg_req_out, since_rst));
    end
  end

  always @(posedge clk) begin : p_timeout
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin : p_main
    logic [63:0] rd;
    logic [31:0] rnd_sel;
    logic [63:0] rnd_dat;
    int unsigned idx;
    int unsigned idx_list[$];
    seed    = 32'h2bf1;
    rst_n   = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_sel  = '0;
    wb_wdat = '0;
    dbg_req = 1'b1;
    dbg_en  = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (exit_val == '0) else report_error("exit_o not zero after reset");

    // Whole table, then indexes past its end
    for (int i = 0; i < soc_pkg::RomWords; i++) begin
      rom_check(i, i[0]);
    end
    rom_check(16, 1'b0);
    rom_check(100, 1'b1);
    rom_check(511, 1'b0);

    // Word 0 and the exit word always plus random words
    idx_list = '{0, soc_pkg::ExitWord};
    repeat (10) begin
      idx_list.push_back($unsigned($random(seed)) % soc_pkg::SramWords);
    end
    foreach (idx_list[k]) begin
      idx = idx_list[k];
      if (!written[idx]) begin
        sram_write(idx, 8'hff, {$random(seed), $random(seed)}, 1'b0);
        written[idx] = 1'b1;
        used_words.push_back(idx);
      end
      rnd_sel = $random(seed);
      rnd_dat = {$random(seed), $random(seed)};
      sram_write(idx, rnd_sel[7:0], rnd_dat, k % 2);
      sram_check(idx);
    end

    // Unmapped and ROM write accesses
    bus_xfer(1'b0, 32'h4000_0000, 8'hff, 64'h0, 1'b1, 1'b0, rd);
    bus_xfer(1'b1, 32'h0000_0000, 8'hff, 64'h1111_2222_3333_4444, 1'b1, 1'b1, rd);
    bus_xfer(1'b1, soc_pkg::RomBase + 32'h10, 8'hff, 64'h5555_6666_7777_8888, 1'b1, 1'b0, rd);
    // Just past the SRAM where word 0 would alias
    bus_xfer(1'b1, 32'h8000_2000, 8'hff, 64'h9999_aaaa_bbbb_cccc, 1'b1, 1'b0, rd);
    bus_xfer(1'b0, 32'h0001_1000, 8'hff, 64'h0, 1'b1, 1'b0, rd);
    foreach (used_words[k]) begin
      sram_check(used_words[k]);
    end

    // Exit word with partial selects and then a hold period
    sram_write(soc_pkg::ExitWord, 8'h0f, 64'h0bad_f00d_c0de_0001, 1'b0);
    sram_write(soc_pkg::ExitWord, 8'h02, 64'h0000_0000_0000_7700, 1'b1);
    repeat (4) begin
      @(negedge clk);
      assert (exit_val == exit_exp) else report_error("exit_o did not hold");
    end

    // Debug enable off, then on again
    @(posedge clk);
    dbg_en <= 1'b0;
    repeat (3) @(negedge clk);
    assert (!dbg_req_out) else report_error("debug_req_o high with debug disabled");
    @(posedge clk);
    dbg_en <= 1'b1;
    repeat (3) @(negedge clk);

    // Request itself dropped while debug stays enabled
    @(posedge clk);
    dbg_req <= 1'b0;
    repeat (3) @(negedge clk);
    assert (!dbg_req_out) else report_error("debug_req_o high without a request");
    @(posedge clk);
    dbg_req <= 1'b1;
    repeat (3) @(negedge clk);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* wb_soc_mem.f */
+incdir+include
hdl/soc_pkg.sv
hdl/wb_addr_decode.sv
hdl/boot_rom.sv
hdl/wb_sram.sv
hdl/debug_req_gate.sv
hdl/wb_soc_top.sv
sim/tb_wb_soc_top.sv
